/* logic/bp_params.svh */
/*
 * branch predictor sizing macros
 * table geometry, fetch width, queue depth and statistics width
 */
`ifndef BP_PARAMS_SVH
`define BP_PARAMS_SVH

// instruction address width
`define BP_ADDR_W 24
// predictions returned per fetch cycle
`define BP_FETCH_SLOTS 2

// table index is low pc bits joined with global history
`define BP_HIST_W 2
`define BP_PC_IDX_W 7
`define BP_IDX_W 9

// update queue entries, must stay a power of two
`define BP_QUEUE_DEPTH 8
// width of the update and mispredict statistics
`define BP_CNT_W 32
// weakly not-taken, value left behind by a clear sweep
`define BP_CNT_WEAK_NT 1

`endif

/* logic/bp_pkg.sv */
/*
 * branch predictor shared types
 * controller states and apb register word addresses
 */
`default_nettype none

package bp_pkg;

	// ============================================================
	// controller states
	// ============================================================
	typedef enum logic [1:0] {
		BP_CLEAR = 2'd0,
		BP_IDLE  = 2'd1,
		BP_RUN   = 2'd2
	} bp_state_t;

	// ============================================================
	// register map, byte addresses of 32-bit words
	// ============================================================
	typedef enum logic [3:0] {
		REG_CTRL    = 4'h0,
		REG_STATUS  = 4'h4,
		REG_UPDATES = 4'h8,
		REG_MISPRED = 4'hC
	} bp_reg_t;

endpackage

`default_nettype wire

/* logic/bp_clear_counter.sv */
/*
 * clear sweep counter
 * walks every table index once after a start or a reset
 */
`timescale 1ns/1ps
`default_nettype none
`include "bp_params.svh"

module bp_clear_counter (
	input  wire logic                 clk,
	input  wire logic                 rst,
	input  wire logic                 start,
	output logic [`BP_IDX_W-1:0]      idx,
	output logic                      busy,
	output logic                      done
);

	localparam int IDX_W = `BP_IDX_W;

	logic last;

	assign last = (idx == {IDX_W{1'b1}});

	// a restart in the final cycle wins, so done is held off
	assign done = busy && last && !start;

	// reset begins a sweep, the controller also resets into clear
	always_ff @(posedge clk) begin
		if (rst || start) begin
			idx  <= '0;
			busy <= 1'b1;
		end else if (busy) begin
			idx <= idx + IDX_W'(1);
			if (last)
				busy <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* logic/bp_ctrl_fsm.sv */
/*
 * predictor controller
 * sequences the table clear sweep, idle and run
 */
`timescale 1ns/1ps
`default_nettype none

module bp_ctrl_fsm import bp_pkg::*; (
	input  wire logic clk,
	input  wire logic rst,
	input  wire logic enable,
	input  wire logic clear_req,
	input  wire logic clear_done,
	output logic      clear_start,
	output bp_state_t state
);

	bp_state_t state_next;

	always_comb begin
		state_next = state;
		case (state)
			BP_CLEAR: begin
				// a request here restarts the sweep, stay put
				if (clear_req)
					state_next = BP_CLEAR;
				else if (clear_done)
					state_next = enable ? BP_RUN : BP_IDLE;
			end
			BP_IDLE: begin
				if (clear_req)
					state_next = BP_CLEAR;
				else if (enable)
					state_next = BP_RUN;
			end
			BP_RUN: begin
				if (clear_req)
					state_next = BP_CLEAR;
				else if (!enable)
					state_next = BP_IDLE;
			end
			default: state_next = BP_CLEAR;
		endcase
	end

	// counter restarts on entry to clear and on a repeated request
	assign clear_start = (state_next == BP_CLEAR) && ((state != BP_CLEAR) || clear_req);

	always_ff @(posedge clk) begin
		if (rst)
			state <= BP_CLEAR;
		else
			state <= state_next;
	end

	a_done_exits: assert property (@(posedge clk) disable iff (rst)
		(state == BP_CLEAR && clear_done) |=> (state != BP_CLEAR));

endmodule

`default_nettype wire

/* logic/bp_update_queue.sv */
/*
 * commit update queue
 * circular fifo of branch outcomes, drops and flags pushes when full
 */
`timescale 1ns/1ps
`default_nettype none
`include "bp_params.svh"

module bp_update_queue (
	input  wire logic                 clk,
	input  wire logic                 rst,
	input  wire logic                 push,
	input  wire logic [`BP_ADDR_W-1:0] push_ip,
	input  wire logic                 push_taken,
	input  wire logic                 pop,
	output logic                      q_valid,
	output logic [`BP_ADDR_W-1:0]     q_ip,
	output logic                      q_taken,
	output logic                      q_empty,
	output logic                      overflow_pulse
);

	localparam int PTR_W = $clog2(`BP_QUEUE_DEPTH);

	// payload storage
	logic [`BP_ADDR_W-1:0] ip_mem [`BP_QUEUE_DEPTH];
	logic                  taken_mem [`BP_QUEUE_DEPTH];

	// msb of each pointer is the wrap bit
	logic [PTR_W:0] wr_ptr;
	logic [PTR_W:0] rd_ptr;
	logic           full;
	logic           push_ok;

	assign q_empty = (wr_ptr == rd_ptr);
	assign full    = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
	                 (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);
	assign push_ok = push && !full;

	// a commit that finds the queue full is lost
	assign overflow_pulse = push && full;

	assign q_valid = !q_empty;
	assign q_ip    = ip_mem[rd_ptr[PTR_W-1:0]];
	assign q_taken = taken_mem[rd_ptr[PTR_W-1:0]];

	always_ff @(posedge clk) begin
		if (push_ok) begin
			ip_mem[wr_ptr[PTR_W-1:0]]    <= push_ip;
			taken_mem[wr_ptr[PTR_W-1:0]] <= push_taken;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push_ok)
				wr_ptr <= wr_ptr + (PTR_W+1)'(1);
			if (pop)
				rd_ptr <= rd_ptr + (PTR_W+1)'(1);
		end
	end

	a_no_pop_empty: assert property (@(posedge clk) disable iff (rst) pop |-> !q_empty);

endmodule

`default_nettype wire

/* logic/bp_history_table.sv */
/*
 * two-bit counter table with global history
 * serves fetch predictions, applies queued updates and sweeps on clear
 */
`timescale 1ns/1ps
`default_nettype none
`include "bp_params.svh"

module bp_history_table import bp_pkg::*; (
	input  wire logic                  clk,
	input  wire logic                  rst,
	input  wire bp_state_t             state,
	input  wire logic [`BP_IDX_W-1:0]  clear_idx,
	input  wire logic [`BP_ADDR_W-1:0] fetch_ip [`BP_FETCH_SLOTS],
	output logic [`BP_FETCH_SLOTS-1:0] predict_taken,
	input  wire logic                  q_valid,
	input  wire logic [`BP_ADDR_W-1:0] q_ip,
	input  wire logic                  q_taken,
	output logic                       q_pop,
	output logic                       upd_pulse,
	output logic                       mispred_pulse
);

	localparam int TABLE_SIZE = 1 << `BP_IDX_W;

	logic [1:0]            table_mem [TABLE_SIZE];
	logic [`BP_HIST_W-1:0] hist;

	// update register, filled by a pop and written on the next edge
	logic                  upd_valid;
	logic [`BP_ADDR_W-1:0] upd_ip;
	logic                  upd_taken;

	logic [`BP_IDX_W-1:0]  wr_idx;
	logic [1:0]            wr_cnt;
	logic [1:0]            wr_cnt_new;
	logic                  clearing;
	logic                  upd_write;

	// ============================================================
	// prediction read, one index per fetch slot
	// ============================================================
	logic [`BP_IDX_W-1:0] rd_idx [`BP_FETCH_SLOTS];

	for (genvar s = 0; s < `BP_FETCH_SLOTS; s++) begin : g_pred
		assign rd_idx[s] = {fetch_ip[s][`BP_PC_IDX_W-1:0], hist};
		// upper counter bit is the taken guess
		assign predict_taken[s] = (state == BP_RUN) && table_mem[rd_idx[s]][1];
	end

	// ============================================================
	// update path
	// ============================================================
	assign clearing = (state == BP_CLEAR);
	assign q_pop    = (state == BP_RUN) && q_valid;

	// counter indexed with the history as it stands at write time
	assign wr_idx = {upd_ip[`BP_PC_IDX_W-1:0], hist};
	assign wr_cnt = table_mem[wr_idx];

	// saturating step toward the outcome
	always_comb begin
		if (upd_taken)
			wr_cnt_new = (wr_cnt == 2'd3) ? 2'd3 : wr_cnt + 2'd1;
		else
			wr_cnt_new = (wr_cnt == 2'd0) ? 2'd0 : wr_cnt - 2'd1;
	end

	// a sweep owns the write port, a pending update is dropped
	assign upd_write     = upd_valid && !clearing;
	assign upd_pulse     = upd_write;
	assign mispred_pulse = upd_write && (upd_taken != wr_cnt[1]);

	always_ff @(posedge clk) begin
		if (q_pop) begin
			upd_ip    <= q_ip;
			upd_taken <= q_taken;
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			upd_valid <= 1'b0;
		else
			upd_valid <= q_pop;
	end

	always_ff @(posedge clk) begin
		if (clearing)
			table_mem[clear_idx] <= 2'(`BP_CNT_WEAK_NT);
		else if (upd_write)
			table_mem[wr_idx] <= wr_cnt_new;
	end

	// newest outcome shifts in at bit 0
	always_ff @(posedge clk) begin
		if (rst || clearing)
			hist <= '0;
		else if (upd_write)
			hist <= {hist[`BP_HIST_W-2:0], upd_taken};
	end

endmodule

`default_nettype wire

/* logic/bp_apb_regs.sv */
/*
 * apb register block
 * control, status and update / mispredict statistics, zero wait states
 */
`timescale 1ns/1ps
`default_nettype none
`include "bp_params.svh"

module bp_apb_regs import bp_pkg::*; (
	input  wire logic        clk,
	input  wire logic        rst,
	input  wire logic        psel,
	input  wire logic        penable,
	input  wire logic        pwrite,
	input  wire logic [3:0]  paddr,
	input  wire logic [31:0] pwdata,
	output logic [31:0]      prdata,
	input  wire bp_state_t   state,
	input  wire logic        q_empty,
	input  wire logic        overflow_pulse,
	input  wire logic        upd_pulse,
	input  wire logic        mispred_pulse,
	output logic             enable,
	output logic             clear_req
);

	logic                 wr_en;
	logic                 clearing;
	logic                 overflow;
	logic [`BP_CNT_W-1:0] upd_cnt;
	logic [`BP_CNT_W-1:0] mispred_cnt;

	// writes land on the access-phase edge
	assign wr_en    = psel && penable && pwrite;
	assign clearing = (state == BP_CLEAR);

	// ctrl bit1 is a command pulse, never stored
	assign clear_req = wr_en && (paddr == REG_CTRL) && pwdata[1];

	// ============================================================
	// control and sticky status
	// ============================================================
	always_ff @(posedge clk) begin
		if (rst) begin
			enable   <= 1'b0;
			overflow <= 1'b0;
		end else begin
			if (wr_en && paddr == REG_CTRL)
				enable <= pwdata[0];
			// write one to clear, a new drop in the same cycle wins
			if (wr_en && paddr == REG_STATUS && pwdata[1])
				overflow <= 1'b0;
			if (overflow_pulse)
				overflow <= 1'b1;
		end
	end

	// ============================================================
	// statistics, held at zero through a clear sweep
	// ============================================================
	always_ff @(posedge clk) begin
		if (rst || clearing) begin
			upd_cnt     <= '0;
			mispred_cnt <= '0;
		end else begin
			if (upd_pulse)
				upd_cnt <= upd_cnt + `BP_CNT_W'(1);
			if (mispred_pulse)
				mispred_cnt <= mispred_cnt + `BP_CNT_W'(1);
		end
	end

	// read mux, valid whenever the slave is selected
	always_comb begin
		prdata = '0;
		if (psel) begin
			case (paddr)
				REG_CTRL:    prdata = {31'd0, enable};
				REG_STATUS:  prdata = {29'd0, q_empty, overflow, clearing};
				REG_UPDATES: prdata = upd_cnt;
				REG_MISPRED: prdata = mispred_cnt;
				default:     prdata = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

/* logic/bp_top.sv */
/*
 * branch direction predictor top level
 */
`timescale 1ns/1ps
`default_nettype none
`include "bp_params.svh"

module bp_top import bp_pkg::*; (
	input  wire logic                  clk,
	input  wire logic                  rst,
	// fetch
	input  wire logic [`BP_ADDR_W-1:0] fetch_ip [`BP_FETCH_SLOTS],
	output logic [`BP_FETCH_SLOTS-1:0] predict_taken,
	// commit
	input  wire logic                  commit_valid,
	input  wire logic [`BP_ADDR_W-1:0] commit_ip,
	input  wire logic                  commit_taken,
	// apb
	input  wire logic                  psel,
	input  wire logic                  penable,
	input  wire logic                  pwrite,
	input  wire logic [3:0]            paddr,
	input  wire logic [31:0]           pwdata,
	output logic [31:0]                prdata
);

	bp_state_t             state;
	logic                  enable;
	logic                  clear_req;
	logic                  clear_start;
	logic                  clear_done;
	logic                  clear_busy;
	logic [`BP_IDX_W-1:0]  clear_idx;

	logic                  q_valid;
	logic [`BP_ADDR_W-1:0] q_ip;
	logic                  q_taken;
	logic                  q_pop;
	logic                  q_empty;
	logic                  overflow_pulse;
	logic                  upd_pulse;
	logic                  mispred_pulse;

	bp_apb_regs apb_regs_inst (
		.clk(clk), .rst(rst),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata),
		.state(state), .q_empty(q_empty), .overflow_pulse(overflow_pulse),
		.upd_pulse(upd_pulse), .mispred_pulse(mispred_pulse),
		.enable(enable), .clear_req(clear_req)
	);

	bp_ctrl_fsm ctrl_fsm_inst (
		.clk(clk), .rst(rst),
		.enable(enable), .clear_req(clear_req), .clear_done(clear_done),
		.clear_start(clear_start), .state(state)
	);

	bp_clear_counter clear_counter_inst (
		.clk(clk), .rst(rst),
		.start(clear_start), .idx(clear_idx), .busy(clear_busy), .done(clear_done)
	);

	bp_update_queue update_queue_inst (
		.clk(clk), .rst(rst),
		.push(commit_valid), .push_ip(commit_ip), .push_taken(commit_taken),
		.pop(q_pop), .q_valid(q_valid), .q_ip(q_ip), .q_taken(q_taken),
		.q_empty(q_empty), .overflow_pulse(overflow_pulse)
	);

	bp_history_table history_table_inst (
		.clk(clk), .rst(rst),
		.state(state), .clear_idx(clear_idx),
		.fetch_ip(fetch_ip), .predict_taken(predict_taken),
		.q_valid(q_valid), .q_ip(q_ip), .q_taken(q_taken), .q_pop(q_pop),
		.upd_pulse(upd_pulse), .mispred_pulse(mispred_pulse)
	);

	// sweep counter and controller must agree on when a clear runs
	a_sweep_in_clear: assert property (@(posedge clk) disable iff (rst)
		clear_busy == (state == BP_CLEAR));

endmodule

`default_nettype wire

/* verif/bp_checker.sv */
/*
 * predictor reference checker
 * cycle model of queue, table, history and registers, compares reads and predictions
 */
`timescale 1ns/1ps
`default_nettype none
`include "bp_params.svh"

module bp_checker import bp_pkg::*; (
	input  wire logic                       clk,
	input  wire logic                       rst,
	input  wire logic [`BP_ADDR_W-1:0]      fetch_ip [`BP_FETCH_SLOTS],
	input  wire logic [`BP_FETCH_SLOTS-1:0] predict_taken,
	input  wire logic                       commit_valid,
	input  wire logic [`BP_ADDR_W-1:0]      commit_ip,
	input  wire logic                       commit_taken,
	input  wire logic                       psel,
	input  wire logic                       penable,
	input  wire logic                       pwrite,
	input  wire logic [3:0]                 paddr,
	input  wire logic [31:0]                pwdata,
	input  wire logic [31:0]                prdata,
	input  wire logic                       chk_rd,
	input  wire logic                       chk_rd_model,
	input  wire logic [31:0]                rd_exp,
	input  wire logic                       chk_pred,
	output int                              rd_errs,
	output int                              pred_errs
);

	localparam int TABLE_SIZE = 1 << `BP_IDX_W;
	localparam int LAST_IDX   = TABLE_SIZE - 1;

	// ============================================================
	// reference state
	// ============================================================
	logic [1:0]            mtable [TABLE_SIZE];
	logic [`BP_HIST_W-1:0] mhist;
	bp_state_t             mstate;
	int                    sweep_idx;
	logic                  menable;
	logic                  moverflow;
	logic [31:0]           mupd_cnt;
	logic [31:0]           mmis_cnt;
	// pending commits, in order
	logic [`BP_ADDR_W-1:0] mq_ip [$];
	logic                  mq_taken [$];
	// entry popped last edge, written this edge
	logic                  mupd_valid;
	logic [`BP_ADDR_W-1:0] mupd_ip;
	logic                  mupd_taken;

	initial begin
		rd_errs   = 0;
		pred_errs = 0;
	end

	function automatic logic [`BP_IDX_W-1:0] index_of(input logic [`BP_ADDR_W-1:0] ip,
			input logic [`BP_HIST_W-1:0] h);
		return {ip[`BP_PC_IDX_W-1:0], h};
	endfunction

	// step one toward the outcome and clamp to the 0..3 range
	function automatic logic [1:0] next_count(input logic [1:0] c, input logic taken);
		int v;
		v = int'(c) + (taken ? 1 : -1);
		if (v > 3)
			v = 3;
		if (v < 0)
			v = 0;
		return v[1:0];
	endfunction

	function automatic logic [31:0] reg_value(input logic [3:0] addr);
		case (addr)
			REG_CTRL:    return {31'd0, menable};
			REG_STATUS:  return {29'd0, (mq_ip.size() == 0), moverflow, (mstate == BP_CLEAR)};
			REG_UPDATES: return mupd_cnt;
			REG_MISPRED: return mmis_cnt;
			default:     return 32'd0;
		endcase
	endfunction

	task automatic reset_table();
		for (int i = 0; i < TABLE_SIZE; i++)
			mtable[i] = 2'(`BP_CNT_WEAK_NT);
	endtask

	task automatic reset_model();
		reset_table();
		mhist      = '0;
		mstate     = BP_CLEAR;
		sweep_idx  = 0;
		menable    = 1'b0;
		moverflow  = 1'b0;
		mupd_cnt   = '0;
		mmis_cnt   = '0;
		mupd_valid = 1'b0;
		mq_ip.delete();
		mq_taken.delete();
	endtask

	// ============================================================
	// compare, then advance the model by one edge
	// ============================================================
	always @(posedge clk) begin
		logic [31:0]                exp_val;
		logic [`BP_FETCH_SLOTS-1:0] exp_pred;
		logic [`BP_IDX_W-1:0]       widx;
		logic                       was_full;
		logic                       wr_acc;
		logic                       clr_req;
		bp_state_t                  nstate;
		if (rst) begin
			reset_model();
		end else begin
			// outputs seen here still belong to the pre-edge state
			if (chk_rd && psel && penable && !pwrite) begin
				exp_val = chk_rd_model ? reg_value(paddr) : rd_exp;
				if (prdata !== exp_val) begin
					$display("Mismatch at %0t: prdata expected %h actual %h",
						$time, exp_val, prdata);
					rd_errs++;
				end
			end
			if (chk_pred) begin
				for (int s = 0; s < `BP_FETCH_SLOTS; s++)
					exp_pred[s] = (mstate == BP_RUN) && mtable[index_of(fetch_ip[s], mhist)][1];
				if (predict_taken !== exp_pred) begin
					$display("Mismatch at %0t: predict_taken expected %b actual %b",
						$time, exp_pred, predict_taken);
					pred_errs++;
				end
			end

			// table write, dropped while a sweep runs
			if (mstate == BP_CLEAR) begin
				mhist    = '0;
				mupd_cnt = '0;
				mmis_cnt = '0;
			end else if (mupd_valid) begin
				widx = index_of(mupd_ip, mhist);
				mupd_cnt++;
				if (mtable[widx][1] != mupd_taken)
					mmis_cnt++;
				mtable[widx] = next_count(mtable[widx], mupd_taken);
				mhist = {mhist[`BP_HIST_W-2:0], mupd_taken};
			end

			// fullness is judged before this edge's pop
			was_full   = (mq_ip.size() == `BP_QUEUE_DEPTH);
			mupd_valid = (mstate == BP_RUN) && (mq_ip.size() != 0);
			if (mupd_valid) begin
				mupd_ip    = mq_ip.pop_front();
				mupd_taken = mq_taken.pop_front();
			end

			wr_acc = psel && penable && pwrite;
			if (wr_acc && paddr == REG_STATUS && pwdata[1])
				moverflow = 1'b0;
			if (commit_valid) begin
				if (was_full) begin
					moverflow = 1'b1;
				end else begin
					mq_ip.push_back(commit_ip);
					mq_taken.push_back(commit_taken);
				end
			end

			// controller, using enable as it stood before the edge
			clr_req = wr_acc && paddr == REG_CTRL && pwdata[1];
			nstate  = mstate;
			if (mstate == BP_CLEAR) begin
				if (clr_req)
					sweep_idx = 0;
				else if (sweep_idx == LAST_IDX)
					nstate = menable ? BP_RUN : BP_IDLE;
				else
					sweep_idx++;
			end else if (clr_req) begin
				nstate    = BP_CLEAR;
				sweep_idx = 0;
				// whole table is weak not-taken once the sweep ends
				reset_table();
			end else if (menable) begin
				nstate = BP_RUN;
			end else begin
				nstate = BP_IDLE;
			end
			if (wr_acc && paddr == REG_CTRL)
				menable = pwdata[0];
			mstate = nstate;
		end
	end

endmodule

`default_nettype wire

/* verif/tb_bp_top.sv */
/*
 * branch predictor testbench
 * table of apb, commit, wait and probe rows checked by a reference model
 */
`timescale 1ns/1ps
`default_nettype none
`include "bp_params.svh"

module tb_bp_top;

	// row kinds
	localparam int K_WR     = 0;
	localparam int K_RD     = 1;
	localparam int K_COMMIT = 2;
	localparam int K_WAIT   = 3;
	localparam int K_PROBE  = 4;
	localparam int CYCLES_PER_ROW = 600;

	logic                       clk;
	logic                       rst;
	logic [`BP_ADDR_W-1:0]      fetch_ip [`BP_FETCH_SLOTS];
	logic [`BP_FETCH_SLOTS-1:0] predict_taken;
	logic                       commit_valid;
	logic [`BP_ADDR_W-1:0]      commit_ip;
	logic                       commit_taken;
	logic                       psel;
	logic                       penable;
	logic                       pwrite;
	logic [3:0]                 paddr;
	logic [31:0]                pwdata;
	logic [31:0]                prdata;

	// tell the checker which cycles carry a comparison
	logic        chk_rd;
	logic        chk_rd_model;
	logic [31:0] rd_exp;
	logic        chk_pred;
	int          rd_errs;
	int          pred_errs;

	// stimulus table, one entry per row in each queue
	// a: apb address, commit ip or slot 0 ip; b: data, expected, outcome or slot 1 ip
	int          row_kind [$];
	logic [31:0] row_a [$];
	logic [31:0] row_b [$];
	// commit from the lcg, or read expected from the model
	bit          row_derived [$];

	logic [31:0] lcg_state;
	logic        after_wait;
	int          cycle_cnt;
	int          cycle_limit;

	bp_top bp_top_inst (
		.clk(clk), .rst(rst),
		.fetch_ip(fetch_ip), .predict_taken(predict_taken),
		.commit_valid(commit_valid), .commit_ip(commit_ip), .commit_taken(commit_taken),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata)
	);

	bp_checker checker_inst (
		.clk(clk), .rst(rst),
		.fetch_ip(fetch_ip), .predict_taken(predict_taken),
		.commit_valid(commit_valid), .commit_ip(commit_ip), .commit_taken(commit_taken),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .prdata(prdata),
		.chk_rd(chk_rd), .chk_rd_model(chk_rd_model), .rd_exp(rd_exp), .chk_pred(chk_pred),
		.rd_errs(rd_errs), .pred_errs(pred_errs)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic add_row(input int kind, input logic [31:0] a, input logic [31:0] b,
			input bit derived);
		row_kind.push_back(kind);
		row_a.push_back(a);
		row_b.push_back(b);
		row_derived.push_back(derived);
	endtask

	// ============================================================
	// row drivers, each starts on a falling edge
	// ============================================================
	task automatic idle_bus();
		psel         = 1'b0;
		penable      = 1'b0;
		pwrite       = 1'b0;
		commit_valid = 1'b0;
		chk_rd       = 1'b0;
		chk_pred     = 1'b0;
	endtask

	task automatic apb_write(input logic [31:0] addr, input logic [31:0] data);
		@(negedge clk);
		idle_bus();
		psel   = 1'b1;
		pwrite = 1'b1;
		paddr  = addr[3:0];
		pwdata = data;
		@(negedge clk);
		penable = 1'b1;
	endtask

	task automatic apb_read_check(input logic [31:0] addr, input logic [31:0] exp_val,
			input bit from_model);
		@(negedge clk);
		idle_bus();
		psel  = 1'b1;
		paddr = addr[3:0];
		@(negedge clk);
		penable      = 1'b1;
		chk_rd       = 1'b1;
		rd_exp       = exp_val;
		chk_rd_model = from_model;
	endtask

	// poll status until the sweep is over and the queue has drained
	task automatic wait_settled();
		logic [31:0] status;
		status = 32'h1;
		while (status[0] || !status[2]) begin
			@(negedge clk);
			idle_bus();
			psel  = 1'b1;
			paddr = 4'h4;
			@(negedge clk);
			penable = 1'b1;
			@(posedge clk);
			status = prdata;
		end
	endtask

	task automatic commit_row(input logic [`BP_ADDR_W-1:0] ip, input logic taken);
		@(negedge clk);
		idle_bus();
		commit_valid = 1'b1;
		commit_ip    = ip;
		commit_taken = taken;
	endtask

	task automatic probe_row(input logic [31:0] ip0, input logic [31:0] ip1, input logic check);
		@(negedge clk);
		idle_bus();
		fetch_ip[0] = ip0[`BP_ADDR_W-1:0];
		fetch_ip[1] = ip1[`BP_ADDR_W-1:0];
		chk_pred    = check;
	endtask

	// ============================================================
	// stimulus table
	// ============================================================
	task automatic build_table();
		// after reset, disabled, everything not-taken
		add_row(K_WAIT, 0, 0, 0);
		add_row(K_PROBE, 32'h10, 32'h123, 0);
		add_row(K_PROBE, 32'h7f, 32'habcdef, 0);
		add_row(K_RD, 32'h4, 32'h4, 0);
		add_row(K_RD, 32'h0, 32'h0, 0);
		// enable, drive 0x40 up to strong taken then one not-taken
		add_row(K_WR, 32'h0, 32'h1, 0);
		for (int k = 0; k < 4; k++)
			add_row(K_COMMIT, 32'h40, 32'h1, 0);
		add_row(K_WAIT, 0, 0, 0);
		add_row(K_PROBE, 32'h40, 32'h40, 0);
		add_row(K_COMMIT, 32'h40, 32'h0, 0);
		// two taken on 0x05 bring the history back to 11
		add_row(K_COMMIT, 32'h05, 32'h1, 0);
		add_row(K_COMMIT, 32'h05, 32'h1, 0);
		add_row(K_WAIT, 0, 0, 0);
		add_row(K_PROBE, 32'h40, 32'h05, 0);
		add_row(K_RD, 32'h8, 32'd7, 0);
		add_row(K_RD, 32'hc, 32'd6, 0);
		// same address under two histories
		add_row(K_COMMIT, 32'h22, 32'h0, 0);
		add_row(K_COMMIT, 32'h22, 32'h0, 0);
		add_row(K_COMMIT, 32'h11, 32'h1, 0);
		add_row(K_COMMIT, 32'h22, 32'h0, 0);
		add_row(K_COMMIT, 32'h22, 32'h0, 0);
		add_row(K_WAIT, 0, 0, 0);
		add_row(K_PROBE, 32'h11, 32'h11, 0);
		add_row(K_COMMIT, 32'h33, 32'h1, 0);
		add_row(K_COMMIT, 32'h33, 32'h1, 0);
		add_row(K_WAIT, 0, 0, 0);
		add_row(K_PROBE, 32'h11, 32'h22, 0);
		// random commits, mispredicts counted by the model
		for (int k = 0; k < 24; k++)
			add_row(K_COMMIT, 0, 0, 1);
		add_row(K_WAIT, 0, 0, 0);
		add_row(K_RD, 32'h8, 32'd38, 0);
		add_row(K_RD, 32'hc, 32'd0, 1);
		// disabled queue holds 8, the last two commits are dropped
		add_row(K_WR, 32'h0, 32'h0, 0);
		add_row(K_RD, 32'h0, 32'h0, 0);
		for (int k = 0; k < 10; k++)
			add_row(K_COMMIT, 32'h50 + 32'(k), 32'h1, 0);
		add_row(K_RD, 32'h4, 32'h2, 0);
		add_row(K_WR, 32'h4, 32'h2, 0);
		add_row(K_RD, 32'h4, 32'h0, 0);
		add_row(K_WR, 32'h0, 32'h1, 0);
		add_row(K_WAIT, 0, 0, 0);
		add_row(K_PROBE, 32'h58, 32'h59, 0);
		add_row(K_PROBE, 32'h50, 32'h51, 0);
		add_row(K_RD, 32'h8, 32'd46, 0);
		add_row(K_RD, 32'h4, 32'h4, 0);
		// clear while running, enable kept
		add_row(K_WR, 32'h0, 32'h3, 0);
		add_row(K_WAIT, 0, 0, 0);
		add_row(K_PROBE, 32'h40, 32'h05, 0);
		add_row(K_PROBE, 32'h11, 32'h58, 0);
		add_row(K_RD, 32'h8, 32'd0, 0);
		add_row(K_RD, 32'hc, 32'd0, 0);
		add_row(K_RD, 32'h0, 32'h1, 0);
		add_row(K_RD, 32'h4, 32'h4, 0);
	endtask

	// ============================================================
	// main sequence
	// ============================================================
	initial begin
		rst          = 1'b1;
		idle_bus();
		paddr        = '0;
		pwdata       = '0;
		commit_ip    = '0;
		commit_taken = 1'b0;
		rd_exp       = '0;
		chk_rd_model = 1'b0;
		fetch_ip[0]  = '0;
		fetch_ip[1]  = '0;
		lcg_state    = 32'h210c;
		after_wait   = 1'b0;
		cycle_cnt    = 0;
		build_table();
		cycle_limit = row_kind.size() * CYCLES_PER_ROW;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		for (int i = 0; i < row_kind.size(); i++) begin
			case (row_kind[i])
				K_WR:    apb_write(row_a[i], row_b[i]);
				K_RD:    apb_read_check(row_a[i], row_b[i], row_derived[i]);
				K_WAIT:  wait_settled();
				K_PROBE: probe_row(row_a[i], row_b[i], after_wait);
				default: begin
					if (row_derived[i]) begin
						lcg_state = lcg_next(lcg_state);
						commit_row(lcg_state[31:8], lcg_state[16]);
					end else begin
						commit_row(row_a[i][`BP_ADDR_W-1:0], row_b[i][0]);
					end
				end
			endcase
			// probes are only judged right after the table has settled
			after_wait = (row_kind[i] == K_WAIT) || (after_wait && row_kind[i] == K_PROBE);
		end
		@(negedge clk);
		idle_bus();
		repeat (2) @(negedge clk);
		$display("error counts: prdata %0d, predict_taken %0d", rd_errs, pred_errs);
		if (rd_errs + pred_errs == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	// run limit scaled by the table length
	always @(posedge clk) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
			$display("timeout: run hung after %0d cycles without finishing the table",
				cycle_cnt);
			$display("error counts: prdata %0d, predict_taken %0d", rd_errs, pred_errs);
			$display("Finished with errors");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* list.f */
+incdir+logic
logic/bp_pkg.sv
logic/bp_clear_counter.sv
logic/bp_ctrl_fsm.sv
logic/bp_update_queue.sv
logic/bp_history_table.sv
logic/bp_apb_regs.sv
logic/bp_top.sv
verif/bp_checker.sv
verif/tb_bp_top.sv

/* Makefile */
# Verilator build and run for the branch predictor testbench

VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := tb_bp_top
FILELIST  := list.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := Finished with no errors

SOURCES   := $(shell grep -v '^+' $(FILELIST)) $(wildcard logic/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
